// File: design/read_engine_params.svh
// Read engine widths

`ifndef READ_ENGINE_PARAMS_SVH
`define READ_ENGINE_PARAMS_SVH

// Byte address width of the host memory port
`define READ_ENGINE_ADDR_BITS 32

// One memory line is a single 64-bit word
`define READ_ENGINE_DATA_BITS 64

// Width of the programmed line count
`define READ_ENGINE_LEN_BITS 16

// Register index and register data widths on the software side
`define READ_ENGINE_CSR_ADDR_BITS 3
`define READ_ENGINE_CSR_DATA_BITS 32

`endif

// File: design/read_engine_pkg.sv
// Read engine types

`default_nettype none

`include "read_engine_params.svh"

package read_engine_pkg;

    // A read request carries only the byte address of one line
    typedef struct packed {
        logic [`READ_ENGINE_ADDR_BITS-1:0] addr;
    } mem_req_t;

    // A read response returns one line and a poison flag
    // Poisoned data is bad and must be kept out of the sum
    typedef struct packed {
        logic [`READ_ENGINE_DATA_BITS-1:0] data;
        logic                              poison;
    } mem_rsp_t;

    // Register map seen by software
    typedef enum logic [`READ_ENGINE_CSR_ADDR_BITS-1:0] {
        REG_BASE   = 3'd0,
        REG_LEN    = 3'd1,
        REG_CTRL   = 3'd2,
        REG_STATUS = 3'd3,
        REG_SUM_LO = 3'd4,
        REG_SUM_HI = 3'd5,
        REG_POISON = 3'd6
    } csr_reg_e;

    // Run setup handed from the register block to the datapath
    typedef struct packed {
        logic [`READ_ENGINE_ADDR_BITS-1:0] base;
        logic [`READ_ENGINE_LEN_BITS-1:0]  len;
    } run_cfg_t;

    // Results handed back from the accumulator to the register block
    typedef struct packed {
        logic [`READ_ENGINE_DATA_BITS-1:0] sum;
        logic [`READ_ENGINE_LEN_BITS-1:0]  poison_cnt;
    } run_result_t;

endpackage

`default_nettype wire

// File: design/fifo2.sv
// Two-slot pipelined FIFO

`timescale 1ns/1ns
`default_nettype none

module fifo2
#(
    parameter type T = logic
)
(
    input  logic clk,
    input  logic reset,

    input  T     enq_data,
    input  logic enq_en,
    output logic notFull,

    output T     first,
    input  logic deq_en,
    output logic notEmpty
);

    // Slot 0 is the holding slot, slot 1 drives the output
    logic [1:0] valid;
    T           slot_hold;
    T           slot_out;

    // Space is only reported while the holding slot is free
    assign notFull  = ~valid[0];
    assign notEmpty = valid[1];
    assign first    = slot_out;

    // Occupancy of the two slots
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid <= 2'b00;
        end
        else if (!valid[1] || deq_en)
        begin
            // The output slot refills from the holding slot or from the input
            // Both cannot hold data at once, so the holding slot drains here
            valid[0] <= 1'b0;
            valid[1] <= valid[0] || enq_en;
        end
        else
        begin
            // Output slot is stalled, so a new entry lands in the holding slot
            valid[0] <= valid[0] || enq_en;
        end
    end

    // Payload movement
    always_ff @(posedge clk)
    begin
        // Load the output slot whenever it is empty or being dequeued
        if (!valid[1] || deq_en)
        begin
            slot_out <= valid[0] ? slot_hold : enq_data;
        end

        // The holding slot captures the input every cycle it is empty
        // An enqueue is never accepted while it is full, so nothing is lost
        if (!valid[0])
        begin
            slot_hold <= enq_data;
        end
    end

endmodule

`default_nettype wire

// File: design/read_csr.sv
// Read engine register block

`timescale 1ns/1ns
`default_nettype none

`include "read_engine_params.svh"

module read_csr
    import read_engine_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,

    // Software register port
    input  logic                                  csr_wr_en,
    input  logic                                  csr_rd_en,
    input  logic [`READ_ENGINE_CSR_ADDR_BITS-1:0] csr_addr,
    input  logic [`READ_ENGINE_CSR_DATA_BITS-1:0] csr_wr_data,
    output logic [`READ_ENGINE_CSR_DATA_BITS-1:0] csr_rd_data,
    output logic                                  csr_rd_valid,

    // Run control towards the datapath
    output run_cfg_t                              run_cfg,
    output logic                                  run_start,
    input  logic                                  run_done,
    input  run_result_t                           run_result
);

    localparam int CSR_W = `READ_ENGINE_CSR_DATA_BITS;
    localparam int LEN_W = `READ_ENGINE_LEN_BITS;

    run_cfg_t         cfg_q;
    logic             busy;
    logic             done;
    logic             start_wr;
    logic             start_ok;
    logic [CSR_W-1:0] rd_mux;

    assign run_cfg = cfg_q;

    // A control write with bit 0 set asks for a new run
    assign start_wr = csr_wr_en && (csr_addr == REG_CTRL) && csr_wr_data[0];
    // The request only counts while no run is in flight
    assign start_ok = start_wr && !busy;

    // Base and length registers
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cfg_q <= '0;
        end
        else if (csr_wr_en)
        begin
            if (csr_addr == REG_BASE)
            begin
                cfg_q.base <= csr_wr_data;
            end
            if (csr_addr == REG_LEN)
            begin
                cfg_q.len <= csr_wr_data[LEN_W-1:0];
            end
        end
    end

    // Start pulse and the busy and done status bits
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            run_start <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            run_start <= start_ok;
            if (start_ok)
            begin
                busy <= 1'b1;
                done <= 1'b0;
            end
            else if (run_done)
            begin
                // The accumulator only signals completion of an active run
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // Readback decode where control and unmapped indices return zero
    always_comb
    begin
        rd_mux = '0;
        case (csr_reg_e'(csr_addr))
            REG_BASE:   rd_mux = cfg_q.base;
            REG_LEN:    rd_mux = CSR_W'(cfg_q.len);
            REG_STATUS: rd_mux = CSR_W'({done, busy});
            REG_SUM_LO: rd_mux = run_result.sum[CSR_W-1:0];
            REG_SUM_HI: rd_mux = run_result.sum[2*CSR_W-1:CSR_W];
            REG_POISON: rd_mux = CSR_W'(run_result.poison_cnt);
            default:    rd_mux = '0;
        endcase
    end

    // Read data follows the read strobe by exactly one cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            csr_rd_valid <= 1'b0;
        end
        else
        begin
            csr_rd_valid <= csr_rd_en;
        end
    end

    always_ff @(posedge clk)
    begin
        csr_rd_data <= rd_mux;
    end

endmodule

`default_nettype wire

// File: design/read_req_gen.sv
// Read request generator

`timescale 1ns/1ns
`default_nettype none

`include "read_engine_params.svh"

module read_req_gen
    import read_engine_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // Run setup from the register block
    input  run_cfg_t run_cfg,
    input  logic     run_start,

    // Enqueue side of the request FIFO
    output mem_req_t req,
    output logic     req_en,
    input  logic     req_notFull
);

    // Address step between consecutive lines
    localparam int LINE_BYTES = `READ_ENGINE_DATA_BITS / 8;

    logic [`READ_ENGINE_ADDR_BITS-1:0] addr_q;
    logic [`READ_ENGINE_LEN_BITS-1:0]  remain_q;

    // Issue while lines remain and the FIFO has room
    assign req_en   = (remain_q != '0) && req_notFull;
    assign req.addr = addr_q;

    // Remaining line count
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            remain_q <= '0;
        end
        else if (run_start)
        begin
            // A zero length leaves the generator idle for the whole run
            remain_q <= run_cfg.len;
        end
        else if (req_en)
        begin
            remain_q <= remain_q - 1'b1;
        end
    end

    // Current line address
    always_ff @(posedge clk)
    begin
        if (run_start)
        begin
            addr_q <= run_cfg.base;
        end
        else if (req_en)
        begin
            // Wraps at the top of the address space
            addr_q <= addr_q + LINE_BYTES;
        end
    end

endmodule

`default_nettype wire

// File: design/read_rsp_sum.sv
// Read response accumulator

`timescale 1ns/1ns
`default_nettype none

`include "read_engine_params.svh"

module read_rsp_sum
    import read_engine_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Run setup from the register block
    input  run_cfg_t    run_cfg,
    input  logic        run_start,

    // Dequeue side of the response FIFO
    input  mem_rsp_t    rsp,
    input  logic        rsp_notEmpty,
    output logic        rsp_deq,

    // Completion and results back to the register block
    output logic        run_done,
    output run_result_t run_result
);

    logic                             active;
    logic [`READ_ENGINE_LEN_BITS-1:0] len_q;
    logic [`READ_ENGINE_LEN_BITS-1:0] rcv_cnt;
    logic [`READ_ENGINE_LEN_BITS-1:0] rcv_next;
    run_result_t                      result_q;

    // Take every response that is present while a run is open
    assign rsp_deq    = rsp_notEmpty && active;
    assign rcv_next   = rcv_cnt + 1'b1;
    assign run_result = result_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active   <= 1'b0;
            run_done <= 1'b0;
            len_q    <= '0;
            rcv_cnt  <= '0;
            result_q <= '0;
        end
        else
        begin
            run_done <= 1'b0;
            if (run_start)
            begin
                // Results restart from zero at every run
                len_q    <= run_cfg.len;
                rcv_cnt  <= '0;
                result_q <= '0;
                // With no lines to fetch the run completes straight away
                active   <= (run_cfg.len != '0);
                run_done <= (run_cfg.len == '0);
            end
            else if (rsp_deq)
            begin
                rcv_cnt <= rcv_next;
                if (rsp.poison)
                begin
                    result_q.poison_cnt <= result_q.poison_cnt + 1'b1;
                end
                else
                begin
                    // Plain modular sum over the good lines
                    result_q.sum <= result_q.sum + rsp.data;
                end
                // Last line of the run closes it
                if (rcv_next == len_q)
                begin
                    active   <= 1'b0;
                    run_done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/read_engine_top.sv
// Streaming read engine top

`timescale 1ns/1ns
`default_nettype none

`include "read_engine_params.svh"

module read_engine_top
    import read_engine_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,

    // Software register port
    input  logic                                  csr_wr_en,
    input  logic                                  csr_rd_en,
    input  logic [`READ_ENGINE_CSR_ADDR_BITS-1:0] csr_addr,
    input  logic [`READ_ENGINE_CSR_DATA_BITS-1:0] csr_wr_data,
    output logic [`READ_ENGINE_CSR_DATA_BITS-1:0] csr_rd_data,
    output logic                                  csr_rd_valid,

    // The memory pulls its requests from the request FIFO
    output mem_req_t                              mem_req,
    output logic                                  mem_req_valid,
    input  logic                                  mem_req_deq,

    // The memory pushes its responses into the response FIFO
    input  mem_rsp_t                              mem_rsp,
    input  logic                                  mem_rsp_en,
    output logic                                  mem_rsp_ready
);

    // Run control between the register block and the datapath
    run_cfg_t    run_cfg;
    logic        run_start;
    logic        run_done;
    run_result_t run_result;

    // Generator to request FIFO
    mem_req_t    gen_req;
    logic        gen_req_en;
    logic        req_notFull;

    // Response FIFO to accumulator
    mem_rsp_t    rsp_first;
    logic        rsp_notEmpty;
    logic        rsp_deq;

    read_csr i_read_csr (
        .clk          (clk),
        .reset        (reset),
        .csr_wr_en    (csr_wr_en),
        .csr_rd_en    (csr_rd_en),
        .csr_addr     (csr_addr),
        .csr_wr_data  (csr_wr_data),
        .csr_rd_data  (csr_rd_data),
        .csr_rd_valid (csr_rd_valid),
        .run_cfg      (run_cfg),
        .run_start    (run_start),
        .run_done     (run_done),
        .run_result   (run_result)
    );

    read_req_gen i_read_req_gen (
        .clk         (clk),
        .reset       (reset),
        .run_cfg     (run_cfg),
        .run_start   (run_start),
        .req         (gen_req),
        .req_en      (gen_req_en),
        .req_notFull (req_notFull)
    );

    // The notEmpty level of the outgoing requests doubles as the request valid
    fifo2 #(.T(mem_req_t)) req_fifo (
        .clk      (clk),
        .reset    (reset),
        .enq_data (gen_req),
        .enq_en   (gen_req_en),
        .notFull  (req_notFull),
        .first    (mem_req),
        .deq_en   (mem_req_deq),
        .notEmpty (mem_req_valid)
    );

    // For incoming responses notFull is the ready level seen by the memory
    fifo2 #(.T(mem_rsp_t)) rsp_fifo (
        .clk      (clk),
        .reset    (reset),
        .enq_data (mem_rsp),
        .enq_en   (mem_rsp_en),
        .notFull  (mem_rsp_ready),
        .first    (rsp_first),
        .deq_en   (rsp_deq),
        .notEmpty (rsp_notEmpty)
    );

    read_rsp_sum i_read_rsp_sum (
        .clk          (clk),
        .reset        (reset),
        .run_cfg      (run_cfg),
        .run_start    (run_start),
        .rsp          (rsp_first),
        .rsp_notEmpty (rsp_notEmpty),
        .rsp_deq      (rsp_deq),
        .run_done     (run_done),
        .run_result   (run_result)
    );

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.sv
// In-order host memory model

`timescale 1ns/1ns
`default_nettype none

module tb_mem_model
    import read_engine_pkg::*;
#(
    parameter int SEED = 1
)
(
    input  logic     clk,
    input  logic     reset,

    // Requests are pulled out of the DUT request FIFO
    input  mem_req_t mem_req,
    input  logic     mem_req_valid,
    output logic     mem_req_deq,

    // Responses are pushed into the DUT response FIFO
    output mem_rsp_t mem_rsp,
    output logic     mem_rsp_en,
    input  logic     mem_rsp_ready,

    // Traffic shaping rates are in percent and the delay is in cycles
    input  int       req_rate,
    input  int       rsp_rate,
    input  int       poison_rate,
    input  int       max_delay
);

    integer      seed;
    int          cycle;
    logic        req_allow = 1'b0;
    logic        rsp_allow = 1'b0;
    logic        rsp_pend  = 1'b0;
    mem_rsp_t    rsp_q     = '0;

    // Accepted requests wait for their line with the oldest first
    logic [31:0] pend_addr[$];
    int          pend_due[$];

    // Every dequeued address and every poisoned address for the top to read
    logic [31:0] req_log[$];
    logic [31:0] poison_log[$];

    initial seed = SEED;

    // Line content is a fixed scramble of the whole byte address
    function automatic logic [63:0] line_data(input logic [31:0] addr);
        logic [63:0] mix;
        mix = {addr, ~addr} ^ 64'h9e37_79b9_7f4a_7c15;
        mix = mix * 64'hbf58_476d_1ce4_e5b9;
        return mix ^ (mix >> 29);
    endfunction

    // One weighted coin flip
    function automatic logic draw(input int rate);
        return (($random(seed) & 32'h7fff_ffff) % 100) < rate;
    endfunction

    // The permission bits are registered and the handshakes only follow the DUT levels
    assign mem_req_deq = mem_req_valid && req_allow;
    assign mem_rsp_en  = rsp_pend && rsp_allow && mem_rsp_ready;
    assign mem_rsp     = rsp_q;

    always @(posedge clk)
    begin
        logic        pend_next;
        logic        poison;
        logic [31:0] addr;
        int          wait_cycles;
        if (reset)
        begin
            cycle     <= 0;
            req_allow <= 1'b0;
            rsp_allow <= 1'b0;
            rsp_pend  <= 1'b0;
            pend_addr.delete();
            pend_due.delete();
        end
        else
        begin
            cycle     <= cycle + 1;
            req_allow <= draw(req_rate);
            rsp_allow <= draw(rsp_rate);
            // Take the request and give it a random latency
            if (mem_req_deq)
            begin
                wait_cycles = ($random(seed) & 32'h7fff_ffff) % (max_delay + 1);
                pend_addr.push_back(mem_req.addr);
                pend_due.push_back(cycle + wait_cycles);
                req_log.push_back(mem_req.addr);
            end
            // The response slot frees up when its line was accepted this edge
            pend_next = rsp_pend && !mem_rsp_en;
            if (!pend_next && pend_addr.size() > 0 && pend_due[0] <= cycle)
            begin
                // Lines go back strictly in request order
                addr   = pend_addr.pop_front();
                void'(pend_due.pop_front());
                poison = draw(poison_rate);
                if (poison)
                begin
                    poison_log.push_back(addr);
                end
                rsp_q.data   <= line_data(addr);
                rsp_q.poison <= poison;
                rsp_pend     <= 1'b1;
            end
            else
            begin
                rsp_pend <= pend_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_read_engine.sv
// Read engine testbench

`timescale 1ns/1ns
`default_nettype none

`include "read_engine_params.svh"

module tb_read_engine
    import read_engine_pkg::*;
();

    localparam int SEED       = 45887;
    localparam int RD_TIMEOUT = 20;
    localparam int DONE_POLLS = 2000;

    logic                                  clk;
    logic                                  reset;
    logic                                  csr_wr_en;
    logic                                  csr_rd_en;
    logic [`READ_ENGINE_CSR_ADDR_BITS-1:0] csr_addr;
    logic [`READ_ENGINE_CSR_DATA_BITS-1:0] csr_wr_data;
    logic [`READ_ENGINE_CSR_DATA_BITS-1:0] csr_rd_data;
    logic                                  csr_rd_valid;
    mem_req_t                              mem_req;
    logic                                  mem_req_valid;
    logic                                  mem_req_deq;
    mem_rsp_t                              mem_rsp;
    logic                                  mem_rsp_en;
    logic                                  mem_rsp_ready;

    // Memory traffic shaping
    int          req_rate;
    int          rsp_rate;
    int          poison_rate;
    int          max_delay;

    integer      seed;
    int          errors = 0;
    int          checks = 0;

    // Pending comparisons for the checking process
    string       name_q[$];
    logic [31:0] got_q[$];
    logic [31:0] exp_q[$];

    initial clk = 1'b0;
    always #2 clk = ~clk;

    read_engine_top i_read_engine_top (
        .clk           (clk),
        .reset         (reset),
        .csr_wr_en     (csr_wr_en),
        .csr_rd_en     (csr_rd_en),
        .csr_addr      (csr_addr),
        .csr_wr_data   (csr_wr_data),
        .csr_rd_data   (csr_rd_data),
        .csr_rd_valid  (csr_rd_valid),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_deq   (mem_req_deq),
        .mem_rsp       (mem_rsp),
        .mem_rsp_en    (mem_rsp_en),
        .mem_rsp_ready (mem_rsp_ready)
    );

    tb_mem_model #(.SEED(SEED)) i_mem_model (
        .clk           (clk),
        .reset         (reset),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_deq   (mem_req_deq),
        .mem_rsp       (mem_rsp),
        .mem_rsp_en    (mem_rsp_en),
        .mem_rsp_ready (mem_rsp_ready),
        .req_rate      (req_rate),
        .rsp_rate      (rsp_rate),
        .poison_rate   (poison_rate),
        .max_delay     (max_delay)
    );

    // Expected result of one run built from the line data and the poisoned addresses
    function automatic run_result_t expected_result(input logic [31:0] base, input int len,
                                                    input logic [31:0] poisoned[$]);
        run_result_t res;
        logic [31:0] addr;
        logic        hit;
        res = '0;
        for (int i = 0; i < len; i++)
        begin
            addr = base + 8 * i;
            hit  = 1'b0;
            foreach (poisoned[k])
            begin
                if (poisoned[k] == addr)
                begin
                    hit = 1'b1;
                end
            end
            if (hit)
            begin
                res.poison_cnt = res.poison_cnt + 1'b1;
            end
            else
            begin
                res.sum = res.sum + i_mem_model.line_data(addr);
            end
        end
        return res;
    endfunction

    // Compares everything queued since the last edge
    always @(posedge clk)
    begin
        string       name;
        logic [31:0] got;
        logic [31:0] exp;
        while (name_q.size() > 0)
        begin
            name   = name_q.pop_front();
            got    = got_q.pop_front();
            exp    = exp_q.pop_front();
            checks = checks + 1;
            assert (got == exp)
            else
            begin
                errors = errors + 1;
                $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
            end
        end
    end

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    task automatic end_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        errors = errors + 1;
        $display("Timeout: %s", what);
        end_run();
    endtask

    task automatic set_traffic(input int req_pct, input int rsp_pct, input int poison_pct,
                               input int delay);
        @(posedge clk);
        req_rate    <= req_pct;
        rsp_rate    <= rsp_pct;
        poison_rate <= poison_pct;
        max_delay   <= delay;
    endtask

    task automatic csr_write(input logic [2:0] idx, input logic [31:0] data);
        @(posedge clk);
        csr_wr_en   <= 1'b1;
        csr_addr    <= idx;
        csr_wr_data <= data;
        @(posedge clk);
        csr_wr_en   <= 1'b0;
    endtask

    // Latency counts the edges from the one that took the strobe to valid data
    task automatic csr_read(input logic [2:0] idx, output logic [31:0] data,
                            output int latency);
        logic seen;
        @(posedge clk);
        csr_rd_en <= 1'b1;
        csr_addr  <= idx;
        @(posedge clk);
        csr_rd_en <= 1'b0;
        latency = 0;
        seen    = 1'b0;
        while (!seen && latency < RD_TIMEOUT)
        begin
            @(posedge clk);
            latency = latency + 1;
            seen    = csr_rd_valid;
        end
        if (!seen)
        begin
            timeout_abort("the register block never returned read data");
        end
        else
        begin
            data = csr_rd_data;
        end
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int          polls;
        int          lat;
        status = '0;
        polls  = 0;
        while (!status[1] && polls < DONE_POLLS)
        begin
            csr_read(REG_STATUS, status, lat);
            polls = polls + 1;
        end
        if (!status[1])
        begin
            timeout_abort("the run never reported done");
        end
    endtask

    // One complete run with an optional second start while the first is busy
    task automatic run_lines(input logic [31:0] base, input int len, input logic extra_start);
        int          req_first;
        int          poison_first;
        int          lat;
        logic [31:0] poisoned[$];
        logic [31:0] rd;
        run_result_t want;
        req_first    = i_mem_model.req_log.size();
        poison_first = i_mem_model.poison_log.size();
        csr_write(REG_BASE, base);
        csr_write(REG_LEN, len);
        csr_write(REG_CTRL, 32'h1);
        if (len != 0)
        begin
            // A new start raises busy and drops the done of the previous run
            csr_read(REG_STATUS, rd, lat);
            expect_value("REG_STATUS after start", rd, 32'h1);
        end
        if (extra_start)
        begin
            csr_write(REG_LEN, len + 5);
            csr_write(REG_CTRL, 32'h1);
        end
        wait_done();
        // Done must come with busy clear since a late start would show up as busy here
        csr_read(REG_STATUS, rd, lat);
        expect_value("REG_STATUS after done", rd, 32'h2);
        for (int k = poison_first; k < i_mem_model.poison_log.size(); k++)
        begin
            poisoned.push_back(i_mem_model.poison_log[k]);
        end
        want = expected_result(base, len, poisoned);
        csr_read(REG_SUM_LO, rd, lat);
        expect_value("REG_SUM_LO", rd, want.sum[31:0]);
        csr_read(REG_SUM_HI, rd, lat);
        expect_value("REG_SUM_HI", rd, want.sum[63:32]);
        csr_read(REG_POISON, rd, lat);
        expect_value("REG_POISON", rd, want.poison_cnt);
        expect_value("poisoned lines in range", want.poison_cnt, poisoned.size());
        // One request per line, ascending from the base
        expect_value("request count", i_mem_model.req_log.size() - req_first, len);
        for (int i = 0; i < len && req_first + i < i_mem_model.req_log.size(); i++)
        begin
            expect_value("request address", i_mem_model.req_log[req_first + i], base + 8 * i);
        end
    endtask

    initial
    begin
        logic [31:0] rd;
        int          lat;
        seed        = SEED;
        reset       = 1'b1;
        csr_wr_en   = 1'b0;
        csr_rd_en   = 1'b0;
        csr_addr    = '0;
        csr_wr_data = '0;
        req_rate    = 100;
        rsp_rate    = 100;
        poison_rate = 0;
        max_delay   = 3;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // Idle after reset and then a plain register round trip
        csr_read(REG_STATUS, rd, lat);
        expect_value("REG_STATUS after reset", rd, 32'h0);
        expect_value("mem_req_valid after reset", mem_req_valid, 1'b0);
        expect_value("mem_rsp_ready after reset", mem_rsp_ready, 1'b1);
        csr_write(REG_BASE, 32'h1234_5678);
        csr_read(REG_BASE, rd, lat);
        expect_value("REG_BASE", rd, 32'h1234_5678);
        expect_value("read latency", lat, 1);
        csr_read(3'd7, rd, lat);
        expect_value("unmapped register", rd, 32'h0);

        // Clean runs of one and of many lines
        run_lines(32'h0000_1000, 1, 1'b0);
        run_lines(32'h0002_0040, 37, 1'b0);

        // Poison with heavy stalls on both memory sides
        set_traffic(30, 30, 25, 8);
        run_lines(32'h00ab_cd00, 48, 1'b0);

        // Start while busy must be dropped
        set_traffic(50, 50, 10, 4);
        run_lines(32'h0000_8000, 40, 1'b1);

        // Empty run
        set_traffic(100, 100, 0, 2);
        run_lines(32'h0000_4000, 0, 1'b0);

        // Back-to-back runs at random line-aligned bases
        set_traffic(70, 60, 15, 5);
        for (int r = 0; r < 3; r++)
        begin
            run_lines($random(seed) & 32'hffff_fff8, 12 + 9 * r, 1'b0);
        end

        // Let the checking process drain its queue
        repeat (2) @(posedge clk);
        end_run();
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+design
design/read_engine_pkg.sv
design/fifo2.sv
design/read_csr.sv
design/read_req_gen.sv
design/read_rsp_sum.sv
design/read_engine_top.sv
testbench/tb_mem_model.sv
testbench/tb_read_engine.sv

// File: Bender.yml
package:
  name: read_engine

sources:
  # Synthesizable design, always part of the build
  - include_dirs:
      - design
    files:
      - design/read_engine_pkg.sv
      - design/fifo2.sv
      - design/read_csr.sv
      - design/read_req_gen.sv
      - design/read_rsp_sum.sv
      - design/read_engine_top.sv

  # Simulation only
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_mem_model.sv
      - testbench/tb_read_engine.sv
